//--- hdl/tmu_pkg.sv
/* widths, CSR register map, reset defaults and data types of the texture-mapping engine
   imported by every RTL module of the engine */
`default_nettype none

package tmu_pkg;

	localparam int ADR_W = 25;	// pixel word address

	localparam logic [3:0] CSR_BASE = 4'h0;	// matched against csr_a[13:10]

	localparam logic [4:0] REG_CTRL      = 5'd0;
	localparam logic [4:0] REG_HLAST     = 5'd1;
	localparam logic [4:0] REG_VLAST     = 5'd2;
	localparam logic [4:0] REG_BRIGHT    = 5'd3;
	localparam logic [4:0] REG_CKEY      = 5'd4;	// offset 5 reserved
	localparam logic [4:0] REG_TEX_FBUF  = 5'd6;
	localparam logic [4:0] REG_TEX_HRES  = 5'd7;
	localparam logic [4:0] REG_TEX_VRES  = 5'd8;
	localparam logic [4:0] REG_TEX_HMASK = 5'd9;
	localparam logic [4:0] REG_TEX_VMASK = 5'd10;
	localparam logic [4:0] REG_DST_FBUF  = 5'd11;
	localparam logic [4:0] REG_DST_HRES  = 5'd12;
	localparam logic [4:0] REG_DST_VRES  = 5'd13;
	localparam logic [4:0] REG_DST_HOFS  = 5'd14;
	localparam logic [4:0] REG_DST_VOFS  = 5'd15;
	localparam logic [4:0] REG_SQ_W      = 5'd16;
	localparam logic [4:0] REG_SQ_H      = 5'd17;

	localparam logic [6:0]  DEF_HLAST    = 7'd32;
	localparam logic [6:0]  DEF_VLAST    = 7'd24;
	localparam logic [5:0]  DEF_BRIGHT   = 6'd63;	// unity gain
	localparam logic [10:0] DEF_TEX_HRES = 11'd512;
	localparam logic [10:0] DEF_TEX_VRES = 11'd512;
	localparam logic [10:0] DEF_TEX_MASK = 11'h7ff;
	localparam logic [10:0] DEF_DST_HRES = 11'd640;
	localparam logic [10:0] DEF_DST_VRES = 11'd480;
	localparam logic [10:0] DEF_SQ_SIZE  = 11'd20;

	typedef struct packed {
		logic [6:0]         hlast;
		logic [6:0]         vlast;
		logic [5:0]         brightness;
		logic               chroma_key_en;
		logic [15:0]        chroma_key;
		logic [ADR_W-1:0]   tex_fbuf;
		logic [10:0]        tex_hres;
		logic [10:0]        tex_vres;
		logic [10:0]        tex_hmask;
		logic [10:0]        tex_vmask;
		logic [ADR_W-1:0]   dst_fbuf;
		logic [10:0]        dst_hres;
		logic [10:0]        dst_vres;
		logic signed [11:0] dst_hoffset;
		logic signed [11:0] dst_voffset;
		logic [10:0]        sq_w;
		logic [10:0]        sq_h;
	} tmu_cfg_t;

	localparam tmu_cfg_t CFG_RESET = '{
		hlast: DEF_HLAST, vlast: DEF_VLAST, brightness: DEF_BRIGHT,
		chroma_key_en: 1'b0, chroma_key: 16'd0,
		tex_fbuf: '0, tex_hres: DEF_TEX_HRES, tex_vres: DEF_TEX_VRES,
		tex_hmask: DEF_TEX_MASK, tex_vmask: DEF_TEX_MASK,
		dst_fbuf: '0, dst_hres: DEF_DST_HRES, dst_vres: DEF_DST_VRES,
		dst_hoffset: 12'sd0, dst_voffset: 12'sd0,
		sq_w: DEF_SQ_SIZE, sq_h: DEF_SQ_SIZE
	};

	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} rgb565_t;

	// raw view for the chroma-key compare, rgb view for shading
	typedef union packed {
		logic [15:0] raw;
		rgb565_t     rgb;
	} pixel_t;

	typedef struct packed {
		logic [ADR_W-1:0] tex_adr;
		logic [ADR_W-1:0] dst_adr;
	} scan_item_t;

	typedef struct packed {
		logic [ADR_W-1:0] dst_adr;
		pixel_t           texel;
	} texel_item_t;

endpackage

`default_nettype wire

//--- hdl/tmu_ctlif.sv
/* CSR register file of the texture-mapping engine. The host writes the configuration
   and the start bit here, reads back busy, and receives a one-cycle irq at end of run */
`default_nettype none
`timescale 1ns/1ps

module tmu_ctlif import tmu_pkg::*; (
	input  logic        sys_clk,
	input  logic        sys_rst,

	input  logic [13:0] csr_a,
	input  logic        csr_we,
	input  logic [31:0] csr_di,
	output logic [31:0] csr_do,

	output logic        irq,
	output logic        start,
	input  logic        busy,

	output tmu_cfg_t    cfg
);

	logic       busy_q;
	logic       csr_sel;
	logic [4:0] csr_ofs;

	assign csr_sel = (csr_a[13:10] == CSR_BASE);
	assign csr_ofs = csr_a[4:0];

	// end-of-run detection
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			busy_q <= 1'b0;
			irq <= 1'b0;
		end else begin
			busy_q <= busy;
			irq <= busy_q & ~busy;	// busy just fell
		end
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			start <= 1'b0;
			cfg <= CFG_RESET;
		end else begin
			start <= 1'b0;	// pulse only
			if (csr_sel && csr_we) begin
				case (csr_ofs)
					REG_CTRL: begin
						start <= csr_di[0];
						cfg.chroma_key_en <= csr_di[1];
					end
					REG_HLAST:     cfg.hlast <= csr_di[6:0];
					REG_VLAST:     cfg.vlast <= csr_di[6:0];
					REG_BRIGHT:    cfg.brightness <= csr_di[5:0];
					REG_CKEY:      cfg.chroma_key <= csr_di[15:0];
					REG_TEX_FBUF:  cfg.tex_fbuf <= csr_di[ADR_W:1];	// byte to pixel word
					REG_TEX_HRES:  cfg.tex_hres <= csr_di[10:0];
					REG_TEX_VRES:  cfg.tex_vres <= csr_di[10:0];
					REG_TEX_HMASK: cfg.tex_hmask <= csr_di[10:0];
					REG_TEX_VMASK: cfg.tex_vmask <= csr_di[10:0];
					REG_DST_FBUF:  cfg.dst_fbuf <= csr_di[ADR_W:1];
					REG_DST_HRES:  cfg.dst_hres <= csr_di[10:0];
					REG_DST_VRES:  cfg.dst_vres <= csr_di[10:0];
					REG_DST_HOFS:  cfg.dst_hoffset <= csr_di[11:0];
					REG_DST_VOFS:  cfg.dst_voffset <= csr_di[11:0];
					REG_SQ_W:      cfg.sq_w <= csr_di[10:0];
					REG_SQ_H:      cfg.sq_h <= csr_di[10:0];
					default: ;	// reserved and unmapped offsets
				endcase
			end
		end
	end

	// readback, one cycle after the address
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do <= 32'd0;
		end else begin
			csr_do <= 32'd0;
			if (csr_sel) begin
				case (csr_ofs)
					REG_CTRL:      csr_do <= {30'd0, cfg.chroma_key_en, busy};
					REG_HLAST:     csr_do <= {25'd0, cfg.hlast};
					REG_VLAST:     csr_do <= {25'd0, cfg.vlast};
					REG_BRIGHT:    csr_do <= {26'd0, cfg.brightness};
					REG_CKEY:      csr_do <= {16'd0, cfg.chroma_key};
					REG_TEX_FBUF:  csr_do <= {6'd0, cfg.tex_fbuf, 1'b0};
					REG_TEX_HRES:  csr_do <= {21'd0, cfg.tex_hres};
					REG_TEX_VRES:  csr_do <= {21'd0, cfg.tex_vres};
					REG_TEX_HMASK: csr_do <= {21'd0, cfg.tex_hmask};
					REG_TEX_VMASK: csr_do <= {21'd0, cfg.tex_vmask};
					REG_DST_FBUF:  csr_do <= {6'd0, cfg.dst_fbuf, 1'b0};
					REG_DST_HRES:  csr_do <= {21'd0, cfg.dst_hres};
					REG_DST_VRES:  csr_do <= {21'd0, cfg.dst_vres};
					REG_DST_HOFS:  csr_do <= {{20{cfg.dst_hoffset[11]}}, cfg.dst_hoffset};
					REG_DST_VOFS:  csr_do <= {{20{cfg.dst_voffset[11]}}, cfg.dst_voffset};
					REG_SQ_W:      csr_do <= {21'd0, cfg.sq_w};
					REG_SQ_H:      csr_do <= {21'd0, cfg.sq_h};
					default:       csr_do <= 32'd0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/tmu_scan.sv
/* walks the square grid pixel by pixel, drops pixels outside the destination frame
   and hands texel and destination addresses of visible pixels to the fetch stage */
`default_nettype none
`timescale 1ns/1ps

module tmu_scan import tmu_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst,
	input  tmu_cfg_t   cfg,
	input  logic       start,

	output logic       out_req,
	input  logic       out_ack,
	output scan_item_t out_item,

	output logic       active
);

	logic               walking;
	logic [6:0]         col;	// square column
	logic [6:0]         row;
	logic [10:0]        px;	// pixel inside square
	logic [10:0]        py;
	logic [17:0]        gx;
	logic [17:0]        gy;
	logic signed [19:0] dx;
	logic signed [19:0] dy;
	logic               visible;
	logic               step;
	logic [ADR_W-1:0]   texel_adr;
	logic [ADR_W-1:0]   pixel_adr;

	assign gx = col * cfg.sq_w + px;
	assign gy = row * cfg.sq_h + py;
	assign dx = $signed({2'b00, gx}) + $signed(cfg.dst_hoffset);
	assign dy = $signed({2'b00, gy}) + $signed(cfg.dst_voffset);

	assign visible = !dx[19] && !dy[19] &&
		(dx[18:0] < {8'd0, cfg.dst_hres}) && (dy[18:0] < {8'd0, cfg.dst_vres});

	assign pixel_adr = cfg.dst_fbuf + dy[10:0] * cfg.dst_hres + dx[10:0];
	assign texel_adr = cfg.tex_fbuf + (gy[10:0] & cfg.tex_vmask) * cfg.tex_hres +
		(gx[10:0] & cfg.tex_hmask);

	// clipped pixels never wait for the link
	assign step = walking && (!visible || (!out_req && !out_ack));
	assign active = walking | out_req;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			walking <= 1'b0;
			out_req <= 1'b0;
			col <= '0;
			row <= '0;
			px <= '0;
			py <= '0;
		end else begin
			if (out_req && out_ack)
				out_req <= 1'b0;
			if (start && !active) begin
				walking <= 1'b1;
				col <= '0;
				row <= '0;
				px <= '0;
				py <= '0;
			end else if (step) begin
				if (visible)
					out_req <= 1'b1;
				if (px != cfg.sq_w - 11'd1) begin
					px <= px + 11'd1;
				end else begin
					px <= '0;
					if (py != cfg.sq_h - 11'd1) begin
						py <= py + 11'd1;
					end else begin
						py <= '0;
						if (col != cfg.hlast - 7'd1) begin
							col <= col + 7'd1;
						end else begin
							col <= '0;
							if (row != cfg.vlast - 7'd1)
								row <= row + 7'd1;
							else
								walking <= 1'b0;	// last pixel of last square
						end
					end
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (step && visible) begin
			out_item.tex_adr <= texel_adr;
			out_item.dst_adr <= pixel_adr;
		end
	end

endmodule

`default_nettype wire

//--- hdl/tmu_fetch.sv
/* reads one texel per scan item from the texture memory with a four-phase
   req/ack exchange and passes texel and destination address downstream */
`default_nettype none
`timescale 1ns/1ps

module tmu_fetch import tmu_pkg::*; (
	input  logic             sys_clk,
	input  logic             sys_rst,

	input  logic             in_req,
	output logic             in_ack,
	input  scan_item_t       in_item,

	output logic             tex_req,
	output logic [ADR_W-1:0] tex_adr,
	input  logic             tex_ack,
	input  logic [15:0]      tex_dat,

	output logic             out_req,
	input  logic             out_ack,
	output texel_item_t      out_item,

	output logic             active
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_TEX,	// waiting for texture ack
		S_TEX_END,	// waiting for texture ack to drop
		S_OUT
	} state_t;

	state_t state;

	assign active = (state != S_IDLE);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= S_IDLE;
			in_ack <= 1'b0;
			tex_req <= 1'b0;
			out_req <= 1'b0;
		end else begin
			if (in_ack && !in_req)
				in_ack <= 1'b0;	// sender has released
			case (state)
				S_IDLE: if (in_req && !in_ack) begin
					in_ack <= 1'b1;
					tex_req <= 1'b1;
					state <= S_TEX;
				end
				S_TEX: if (tex_ack) begin
					tex_req <= 1'b0;
					state <= S_TEX_END;
				end
				S_TEX_END: if (!tex_ack && !out_ack) begin
					out_req <= 1'b1;
					state <= S_OUT;
				end
				S_OUT: if (out_ack) begin
					out_req <= 1'b0;
					state <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// item payload
	always_ff @(posedge sys_clk) begin
		if (state == S_IDLE && in_req && !in_ack) begin
			tex_adr <= in_item.tex_adr;
			out_item.dst_adr <= in_item.dst_adr;
		end
		if (state == S_TEX && tex_ack)
			out_item.texel.raw <= tex_dat;	// valid while ack is high
	end

endmodule

`default_nettype wire

//--- hdl/tmu_blend_write.sv
/* last pipeline stage that drops chroma-keyed texels, scales the rest by the brightness
   setting and writes them to the frame memory over four-phase req/ack */
`default_nettype none
`timescale 1ns/1ps

module tmu_blend_write import tmu_pkg::*; (
	input  logic             sys_clk,
	input  logic             sys_rst,

	input  logic [5:0]       brightness,
	input  logic             chroma_key_en,
	input  logic [15:0]      chroma_key,

	input  logic             in_req,
	output logic             in_ack,
	input  texel_item_t      in_item,

	output logic             fb_req,
	output logic [ADR_W-1:0] fb_adr,
	output logic [15:0]      fb_dat,
	input  logic             fb_ack,

	output logic             active
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQ,
		S_END	// frame ack still high
	} state_t;

	state_t      state;
	logic        accept;
	logic        keyed;
	logic [6:0]  scale;
	logic [10:0] r_prod;
	logic [11:0] g_prod;
	logic [10:0] b_prod;
	pixel_t      shaded;

	assign accept = (state == S_IDLE) && in_req && !in_ack;
	assign keyed = chroma_key_en && (in_item.texel.raw == chroma_key);
	assign scale = {1'b0, brightness} + 7'd1;	// 1 to 64

	assign r_prod = in_item.texel.rgb.r * scale;
	assign g_prod = in_item.texel.rgb.g * scale;
	assign b_prod = in_item.texel.rgb.b * scale;

	always_comb begin
		shaded.rgb.r = r_prod[10:6];
		shaded.rgb.g = g_prod[11:6];
		shaded.rgb.b = b_prod[10:6];
	end

	assign active = (state != S_IDLE);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state <= S_IDLE;
			in_ack <= 1'b0;
			fb_req <= 1'b0;
		end else begin
			if (in_ack && !in_req)
				in_ack <= 1'b0;
			case (state)
				S_IDLE: if (accept) begin
					in_ack <= 1'b1;
					if (!keyed) begin	// keyed pixels are consumed silently
						fb_req <= 1'b1;
						state <= S_REQ;
					end
				end
				S_REQ: if (fb_ack) begin
					fb_req <= 1'b0;
					state <= S_END;
				end
				S_END: if (!fb_ack)
					state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept && !keyed) begin
			fb_adr <= in_item.dst_adr;
			fb_dat <= shaded.raw;
		end
	end

endmodule

`default_nettype wire

//--- hdl/tmu_top.sv
/* top level of the texture-mapping engine
   joins the CSR control block to the scan, fetch and blend/write pipeline
   and forms busy as the OR of the stage activity flags */
`default_nettype none
`timescale 1ns/1ps

module tmu_top import tmu_pkg::*; (
	input  logic             sys_clk,
	input  logic             sys_rst,

	input  logic [13:0]      csr_a,
	input  logic             csr_we,
	input  logic [31:0]      csr_di,
	output logic [31:0]      csr_do,
	output logic             irq,

	output logic             tex_req,
	output logic [ADR_W-1:0] tex_adr,
	input  logic             tex_ack,
	input  logic [15:0]      tex_dat,

	output logic             fb_req,
	output logic [ADR_W-1:0] fb_adr,
	output logic [15:0]      fb_dat,
	input  logic             fb_ack
);

	tmu_cfg_t    cfg;
	logic        start;
	logic        busy;
	scan_item_t  scan_item;
	logic        scan_req;
	logic        scan_ack;
	texel_item_t texel_item;
	logic        texel_req;
	logic        texel_ack;
	logic        scan_active;
	logic        fetch_active;
	logic        write_active;

	assign busy = scan_active | fetch_active | write_active;

	tmu_ctlif i_tmu_ctlif (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr_a   (csr_a),
		.csr_we  (csr_we),
		.csr_di  (csr_di),
		.csr_do  (csr_do),
		.irq     (irq),
		.start   (start),
		.busy    (busy),
		.cfg     (cfg)
	);

	tmu_scan i_tmu_scan (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.cfg      (cfg),
		.start    (start),
		.out_req  (scan_req),
		.out_ack  (scan_ack),
		.out_item (scan_item),
		.active   (scan_active)
	);

	tmu_fetch i_tmu_fetch (
		.sys_clk  (sys_clk),
		.sys_rst  (sys_rst),
		.in_req   (scan_req),
		.in_ack   (scan_ack),
		.in_item  (scan_item),
		.tex_req  (tex_req),
		.tex_adr  (tex_adr),
		.tex_ack  (tex_ack),
		.tex_dat  (tex_dat),
		.out_req  (texel_req),
		.out_ack  (texel_ack),
		.out_item (texel_item),
		.active   (fetch_active)
	);

	tmu_blend_write i_tmu_blend_write (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst),
		.brightness    (cfg.brightness),
		.chroma_key_en (cfg.chroma_key_en),
		.chroma_key    (cfg.chroma_key),
		.in_req        (texel_req),
		.in_ack        (texel_ack),
		.in_item       (texel_item),
		.fb_req        (fb_req),
		.fb_adr        (fb_adr),
		.fb_dat        (fb_dat),
		.fb_ack        (fb_ack),
		.active        (write_active)
	);

endmodule

`default_nettype wire

//--- verif/tmu_tb_hash.svh
/* texel value as a function of its word address, included inside the testbench
   modules so the texture memory model and the expected-write builder agree */

function automatic logic [15:0] texel_hash(input logic [24:0] adr);
	logic [31:0] h;
	h = {7'd0, adr} * 32'h9e37_79b1;	// multiplicative spread
	return h[31:16] ^ h[15:0];
endfunction

//--- verif/tmu_checker.sv
/* testbench checker that builds the expected frame write list of each run, compares
   completed frame writes, CSR readback and irq pulses, and reports per test */
`default_nettype none
`timescale 1ns/1ps

module tmu_checker import tmu_pkg::*; (
	input  logic             sys_clk,
	input  logic [31:0]      csr_do,
	input  logic             irq,
	input  logic             fb_req,
	input  logic [ADR_W-1:0] fb_adr,
	input  logic [15:0]      fb_dat,
	input  logic             fb_ack,

	input  logic             arm,	// new test, cfg_exp valid
	input  logic [2:0]       test_id,
	input  logic             exp_run,
	input  tmu_cfg_t         cfg_exp,
	input  logic             csr_chk,
	input  logic [31:0]      csr_exp,
	input  logic             close,
	input  logic             summary,

	output int               error_total
);

	logic [ADR_W-1:0] exp_adr[$];
	logic [15:0]      exp_dat[$];
	logic [ADR_W-1:0] e_adr;
	logic [15:0]      e_dat;
	logic [2:0]       cur_id;
	logic             cur_run;
	logic             csr_chk_q;
	logic [31:0]      csr_exp_q;	// csr_do lags the address by one cycle
	int               writes;
	int               test_errors;
	int               irqs;
	int               tests_run;
	int               tests_failed;

	`include "tmu_tb_hash.svh"

	function automatic string test_name(input logic [2:0] id);
		case (id)
			3'd0: return "reset_readback";
			3'd1: return "plain_fill";
			3'd2: return "clipping";
			3'd3: return "bright_chroma";
			3'd4: return "mask_backpressure";
			3'd5: return "start_while_busy";
			default: return "unknown";
		endcase
	endfunction

	// expected writes in scan order
	function void build_expected(input tmu_cfg_t c);
		int gx;
		int gy;
		int dx;
		int dy;
		int hofs;
		int vofs;
		int br;
		int r;
		int g;
		int b;
		logic [ADR_W-1:0] tadr;
		logic [ADR_W-1:0] dadr;
		logic [15:0] texel;
		hofs = {{20{c.dst_hoffset[11]}}, c.dst_hoffset};
		vofs = {{20{c.dst_voffset[11]}}, c.dst_voffset};
		br = c.brightness + 1;
		for (int row = 0; row < c.vlast; row++) begin
			for (int col = 0; col < c.hlast; col++) begin
				for (int py = 0; py < c.sq_h; py++) begin
					for (int px = 0; px < c.sq_w; px++) begin
						gx = col * c.sq_w + px;
						gy = row * c.sq_h + py;
						dx = gx + hofs;
						dy = gy + vofs;
						if (dx >= 0 && dy >= 0 && dx < c.dst_hres && dy < c.dst_vres) begin
							tadr = c.tex_fbuf + (gy & c.tex_vmask) * c.tex_hres +
								(gx & c.tex_hmask);
							texel = texel_hash(tadr);
							if (!(c.chroma_key_en && texel == c.chroma_key)) begin
								r = (texel[15:11] * br) >> 6;
								g = (texel[10:5] * br) >> 6;
								b = (texel[4:0] * br) >> 6;
								dadr = c.dst_fbuf + dy * c.dst_hres + dx;
								exp_adr.push_back(dadr);
								exp_dat.push_back({r[4:0], g[5:0], b[4:0]});
							end
						end
					end
				end
			end
		end
	endfunction

	task automatic note_error();
		test_errors++;
		error_total++;
	endtask

	initial begin
		error_total = 0;
		tests_run = 0;
		tests_failed = 0;
		test_errors = 0;
		writes = 0;
		irqs = 0;
		cur_id = 3'd0;
		cur_run = 1'b0;
		csr_chk_q = 1'b0;
		csr_exp_q = 32'd0;
	end

	always @(posedge sys_clk) begin
		if (arm) begin
			cur_id = test_id;
			cur_run = exp_run;
			writes = 0;
			test_errors = 0;
			irqs = 0;
			exp_adr.delete();
			exp_dat.delete();
			if (exp_run)
				build_expected(cfg_exp);
		end
		if (csr_chk_q && csr_do !== csr_exp_q) begin
			$display("ERROR %s: csr read expected %h, actual %h",
				test_name(cur_id), csr_exp_q, csr_do);
			note_error();
		end
		csr_chk_q = csr_chk;
		csr_exp_q = csr_exp;
		if (fb_req && fb_ack) begin	// one cycle per write, ack drops after req
			if (exp_adr.size() == 0) begin
				$display("%s: frame write to %h arrived with no write left to expect",
					test_name(cur_id), fb_adr);
				note_error();
			end else begin
				e_adr = exp_adr.pop_front();
				e_dat = exp_dat.pop_front();
				if (fb_adr !== e_adr || fb_dat !== e_dat) begin
					$display("ERROR %s: write %0d expected adr %h dat %h, actual adr %h dat %h",
						test_name(cur_id), writes, e_adr, e_dat, fb_adr, fb_dat);
					note_error();
				end
			end
			writes++;
		end
		if (irq) begin
			irqs++;
			if (exp_adr.size() != 0) begin
				$display("%s: irq pulsed while %0d frame writes were still outstanding",
					test_name(cur_id), exp_adr.size());
				note_error();
			end
		end
		if (close) begin
			if (exp_adr.size() != 0) begin
				$display("%s: %0d expected frame writes never arrived",
					test_name(cur_id), exp_adr.size());
				note_error();
			end
			if (irqs != (cur_run ? 1 : 0)) begin
				$display("%s: irq pulsed %0d times, expected %0d",
					test_name(cur_id), irqs, cur_run ? 1 : 0);
				note_error();
			end
			tests_run++;
			if (test_errors != 0)
				tests_failed++;
			$display("test %s: %0d writes, %0d errors", test_name(cur_id), writes, test_errors);
		end
		if (summary)
			$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total);
	end

endmodule

`default_nettype wire

//--- verif/tb_tmu.sv
/* testbench of the texture-mapping engine with clock, reset, CSR stimulus and models
   of the texture and frame memories, and tmu_checker does the comparing */
`default_nettype none
`timescale 1ns/1ps

module tb_tmu import tmu_pkg::*; ();

	localparam int PIXELS_TOTAL = 36 + 72 + 48 + 60 + 36;	// grid pixels of all runs
	localparam int CYCLE_LIMIT = 2 * PIXELS_TOTAL * 40 + 2000;

	logic             sys_clk;
	logic             sys_rst;
	logic [13:0]      csr_a;
	logic             csr_we;
	logic [31:0]      csr_di;
	logic [31:0]      csr_do;
	logic             irq;
	logic             tex_req;
	logic [ADR_W-1:0] tex_adr;
	logic             tex_ack;
	logic [15:0]      tex_dat;
	logic             fb_req;
	logic [ADR_W-1:0] fb_adr;
	logic [15:0]      fb_dat;
	logic             fb_ack;

	logic             slow_mem;	// long ack delays
	logic [31:0]      tex_rng;
	logic [31:0]      fb_rng;
	int               cycles;
	logic             arm;
	logic             close;
	logic             summary;
	logic             exp_run;
	logic             csr_chk;
	logic [31:0]      csr_exp;
	logic [2:0]       test_id;
	tmu_cfg_t         exp_cfg;
	int               error_total;

	`include "tmu_tb_hash.svh"

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [13:0] reg_adr(input logic [3:0] blk, input logic [4:0] ofs);
		return {blk, 5'd0, ofs};
	endfunction

	function automatic tmu_cfg_t base_cfg(input logic [6:0] hl, input logic [6:0] vl,
		input logic [10:0] w, input logic [10:0] h);
		tmu_cfg_t c;
		c = CFG_RESET;
		c.hlast = hl;
		c.vlast = vl;
		c.sq_w = w;
		c.sq_h = h;
		c.tex_fbuf = 25'h10_0000;
		c.dst_fbuf = 25'h08_0000;
		return c;
	endfunction

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	tmu_top i_tmu_top (
		.sys_clk (sys_clk),
		.sys_rst (sys_rst),
		.csr_a   (csr_a),
		.csr_we  (csr_we),
		.csr_di  (csr_di),
		.csr_do  (csr_do),
		.irq     (irq),
		.tex_req (tex_req),
		.tex_adr (tex_adr),
		.tex_ack (tex_ack),
		.tex_dat (tex_dat),
		.fb_req  (fb_req),
		.fb_adr  (fb_adr),
		.fb_dat  (fb_dat),
		.fb_ack  (fb_ack)
	);

	tmu_checker i_tmu_checker (
		.sys_clk     (sys_clk),
		.csr_do      (csr_do),
		.irq         (irq),
		.fb_req      (fb_req),
		.fb_adr      (fb_adr),
		.fb_dat      (fb_dat),
		.fb_ack      (fb_ack),
		.arm         (arm),
		.test_id     (test_id),
		.exp_run     (exp_run),
		.cfg_exp     (exp_cfg),
		.csr_chk     (csr_chk),
		.csr_exp     (csr_exp),
		.close       (close),
		.summary     (summary),
		.error_total (error_total)
	);

	// texture memory model
	initial begin
		tex_ack = 1'b0;
		tex_dat = 16'd0;
		tex_rng = 32'hfa34_3258;
		forever begin
			@(negedge sys_clk);
			if (tex_req && !tex_ack) begin
				tex_rng = lcg_next(tex_rng);
				repeat (slow_mem ? tex_rng[27:24] : tex_rng[25:24]) @(negedge sys_clk);
				tex_dat = texel_hash(tex_adr);
				tex_ack = 1'b1;
			end else if (!tex_req && tex_ack) begin
				tex_ack = 1'b0;
			end
		end
	end

	// frame memory model
	initial begin
		fb_ack = 1'b0;
		fb_rng = lcg_next(32'hfa34_3258);
		forever begin
			@(negedge sys_clk);
			if (fb_req && !fb_ack) begin
				fb_rng = lcg_next(fb_rng);
				repeat (slow_mem ? fb_rng[27:24] : fb_rng[25:24]) @(negedge sys_clk);
				fb_ack = 1'b1;
			end else if (!fb_req && fb_ack) begin
				fb_ack = 1'b0;
			end
		end
	end

	initial begin
		cycles = 0;
	end

	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	// all tasks start and end on a falling edge
	task automatic csr_write(input logic [13:0] a, input logic [31:0] d);
		csr_a = a;
		csr_di = d;
		csr_we = 1'b1;
		@(negedge sys_clk);
		csr_we = 1'b0;
	endtask

	task automatic csr_check(input logic [13:0] a, input logic [31:0] exp);
		csr_a = a;
		csr_we = 1'b0;
		csr_exp = exp;
		csr_chk = 1'b1;
		@(negedge sys_clk);
		csr_chk = 1'b0;
	endtask

	task automatic check_reg(input logic [4:0] ofs, input logic [31:0] exp);
		csr_check(reg_adr(CSR_BASE, ofs), exp);
	endtask

	task automatic program_cfg(input tmu_cfg_t c);
		csr_write(reg_adr(CSR_BASE, REG_HLAST), {25'd0, c.hlast});
		csr_write(reg_adr(CSR_BASE, REG_VLAST), {25'd0, c.vlast});
		csr_write(reg_adr(CSR_BASE, REG_BRIGHT), {26'd0, c.brightness});
		csr_write(reg_adr(CSR_BASE, REG_CKEY), {16'd0, c.chroma_key});
		csr_write(reg_adr(CSR_BASE, REG_TEX_FBUF), {6'd0, c.tex_fbuf, 1'b0});	// byte address
		csr_write(reg_adr(CSR_BASE, REG_TEX_HRES), {21'd0, c.tex_hres});
		csr_write(reg_adr(CSR_BASE, REG_TEX_VRES), {21'd0, c.tex_vres});
		csr_write(reg_adr(CSR_BASE, REG_TEX_HMASK), {21'd0, c.tex_hmask});
		csr_write(reg_adr(CSR_BASE, REG_TEX_VMASK), {21'd0, c.tex_vmask});
		csr_write(reg_adr(CSR_BASE, REG_DST_FBUF), {6'd0, c.dst_fbuf, 1'b0});
		csr_write(reg_adr(CSR_BASE, REG_DST_HRES), {21'd0, c.dst_hres});
		csr_write(reg_adr(CSR_BASE, REG_DST_VRES), {21'd0, c.dst_vres});
		csr_write(reg_adr(CSR_BASE, REG_DST_HOFS), {{20{c.dst_hoffset[11]}}, c.dst_hoffset});
		csr_write(reg_adr(CSR_BASE, REG_DST_VOFS), {{20{c.dst_voffset[11]}}, c.dst_voffset});
		csr_write(reg_adr(CSR_BASE, REG_SQ_W), {21'd0, c.sq_w});
		csr_write(reg_adr(CSR_BASE, REG_SQ_H), {21'd0, c.sq_h});
	endtask

	task automatic open_test(input logic [2:0] id, input logic run, input tmu_cfg_t c);
		test_id = id;
		exp_run = run;
		exp_cfg = c;
		arm = 1'b1;
		@(negedge sys_clk);
		arm = 1'b0;
	endtask

	task automatic close_test();
		repeat (2) @(negedge sys_clk);	// let the last readback compare
		close = 1'b1;
		@(negedge sys_clk);
		close = 1'b0;
	endtask

	task automatic reset_readback();
		open_test(3'd0, 1'b0, exp_cfg);
		check_reg(REG_CTRL, 32'd0);
		check_reg(REG_HLAST, 32'd32);
		check_reg(REG_VLAST, 32'd24);
		check_reg(REG_BRIGHT, 32'd63);
		check_reg(REG_CKEY, 32'd0);
		check_reg(5'd5, 32'd0);
		check_reg(REG_TEX_FBUF, 32'd0);
		check_reg(REG_TEX_HRES, 32'd512);
		check_reg(REG_TEX_VRES, 32'd512);
		check_reg(REG_TEX_HMASK, 32'h7ff);
		check_reg(REG_TEX_VMASK, 32'h7ff);
		check_reg(REG_DST_FBUF, 32'd0);
		check_reg(REG_DST_HRES, 32'd640);
		check_reg(REG_DST_VRES, 32'd480);
		check_reg(REG_DST_HOFS, 32'd0);
		check_reg(REG_DST_VOFS, 32'd0);
		check_reg(REG_SQ_W, 32'd20);
		check_reg(REG_SQ_H, 32'd20);
		check_reg(5'd18, 32'd0);
		csr_write(reg_adr(CSR_BASE, REG_HLAST), 32'd5);
		csr_write(reg_adr(CSR_BASE, REG_BRIGHT), 32'd12);
		csr_write(reg_adr(CSR_BASE, REG_CKEY), 32'h0000_beef);
		csr_write(reg_adr(CSR_BASE, REG_TEX_FBUF), 32'h0123_4567);
		csr_write(reg_adr(CSR_BASE, REG_DST_FBUF), 32'h0000_0ab1);
		csr_write(reg_adr(CSR_BASE, REG_DST_HOFS), 32'd7);
		csr_write(reg_adr(CSR_BASE, 5'd5), 32'hffff_ffff);
		csr_write(reg_adr(CSR_BASE, REG_CTRL), 32'h2);	// chroma enable, no start
		check_reg(REG_HLAST, 32'd5);
		check_reg(REG_BRIGHT, 32'd12);
		check_reg(REG_CKEY, 32'h0000_beef);
		check_reg(REG_TEX_FBUF, 32'h0123_4566);	// bit 0 dropped
		check_reg(REG_DST_FBUF, 32'h0000_0ab0);
		check_reg(REG_DST_HOFS, 32'd7);
		check_reg(5'd5, 32'd0);
		check_reg(REG_CTRL, 32'h2);
		csr_write(reg_adr(4'h3, REG_HLAST), 32'd99);	// other block
		check_reg(REG_HLAST, 32'd5);
		csr_check(reg_adr(4'h3, REG_HLAST), 32'd0);
		close_test();
	endtask

	task automatic run_test(input logic [2:0] id, input tmu_cfg_t c, input logic slow,
		input logic twice);
		logic [31:0] ctrl;
		ctrl = {30'd0, c.chroma_key_en, 1'b1};
		slow_mem = slow;
		program_cfg(c);
		open_test(id, 1'b1, c);
		csr_write(reg_adr(CSR_BASE, REG_CTRL), ctrl);
		if (slow) begin
			repeat (10) @(negedge sys_clk);
			check_reg(REG_CTRL, ctrl);	// busy mid-run
		end
		if (twice) begin
			repeat (5) @(negedge sys_clk);
			csr_write(reg_adr(CSR_BASE, REG_CTRL), ctrl);
		end
		while (!irq)
			@(negedge sys_clk);
		repeat (30) @(negedge sys_clk);	// room for stray writes or a second irq
		check_reg(REG_CTRL, ctrl & 32'hffff_fffe);
		close_test();
	endtask

	initial begin
		tmu_cfg_t c;
		sys_rst = 1'b1;
		csr_a = 14'd0;
		csr_we = 1'b0;
		csr_di = 32'd0;
		slow_mem = 1'b0;
		arm = 1'b0;
		close = 1'b0;
		summary = 1'b0;
		exp_run = 1'b0;
		csr_chk = 1'b0;
		csr_exp = 32'd0;
		test_id = 3'd0;
		exp_cfg = CFG_RESET;
		repeat (2) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;

		reset_readback();
		c = base_cfg(7'd2, 7'd2, 11'd3, 11'd3);
		run_test(3'd1, c, 1'b0, 1'b0);
		c = base_cfg(7'd3, 7'd2, 11'd4, 11'd3);
		c.dst_hoffset = -12'sd2;
		c.dst_voffset = -12'sd1;
		c.dst_hres = 11'd8;
		c.dst_vres = 11'd4;
		run_test(3'd2, c, 1'b0, 1'b0);
		c = base_cfg(7'd3, 7'd2, 11'd4, 11'd2);
		c.brightness = 6'd31;
		c.chroma_key_en = 1'b1;
		c.chroma_key = texel_hash(c.tex_fbuf + 25'd1);	// texel of pixel (1,0)
		run_test(3'd3, c, 1'b0, 1'b0);
		c = base_cfg(7'd2, 7'd2, 11'd5, 11'd3);
		c.tex_hres = 11'd4;
		c.tex_hmask = 11'd3;
		c.tex_vmask = 11'd1;
		run_test(3'd4, c, 1'b1, 1'b0);
		c = base_cfg(7'd2, 7'd2, 11'd3, 11'd3);
		run_test(3'd5, c, 1'b0, 1'b1);

		summary = 1'b1;
		@(negedge sys_clk);
		summary = 1'b0;
		if (error_total == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tmu_lite.f
+incdir+verif
hdl/tmu_pkg.sv
hdl/tmu_ctlif.sv
hdl/tmu_scan.sv
hdl/tmu_fetch.sv
hdl/tmu_blend_write.sv
hdl/tmu_top.sv
verif/tmu_checker.sv
verif/tb_tmu.sv
